//--- verilog/rx_dsp_cfg.svh
`ifndef RX_DSP_CFG_SVH
`define RX_DSP_CFG_SVH

// lanes per word, lane 0 is the oldest sample
`define CHANNEL_WIDTH 4

// signed ADC code width
`define CODE_BITS 8

// taps per lane, tap j looks j samples back in time
`define FFE_TAPS 3
`define WEIGHT_BITS 8
`define SHIFT_BITS 4

// equalizer estimate and thermometer symbol widths
`define EST_BITS 12
`define SYM_BITS 3

`endif

//--- verilog/rx_dsp_pkg.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

package rx_dsp_pkg;

    // --------------------------------------------------
    // lane element types
    // --------------------------------------------------
    typedef logic signed [`CODE_BITS-1:0]   code_t;
    typedef logic signed [`EST_BITS-1:0]    est_t;
    typedef logic        [`SYM_BITS-1:0]    sym_t;
    typedef logic signed [`WEIGHT_BITS-1:0] weight_t;
    typedef logic        [`SHIFT_BITS-1:0]  shift_t;

    // --------------------------------------------------
    // word types, one element per lane
    // --------------------------------------------------
    typedef code_t [`CHANNEL_WIDTH-1:0] code_word_t;
    typedef est_t  [`CHANNEL_WIDTH-1:0] est_word_t;
    typedef sym_t  [`CHANNEL_WIDTH-1:0] sym_word_t;

    // indexed as weights[tap][lane]
    typedef weight_t [`FFE_TAPS-1:0][`CHANNEL_WIDTH-1:0] ffe_weights_t;

    typedef struct packed {
        ffe_weights_t                   weights;
        shift_t [`CHANNEL_WIDTH-1:0]    shift;
    } ffe_cfg_t;

    // lane offset of the symbol window
    typedef logic [$clog2(`CHANNEL_WIDTH)-1:0] align_t;

endpackage

`default_nettype wire

//--- verilog/code_delay_line.sv
`default_nettype none

module code_delay_line
    import rx_dsp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire code_word_t codes_in,
    output code_word_t      cur_word,
    output code_word_t      prev_word,
    output code_word_t      codes_out
);

    // first stage is the current equalizer window, second holds the tap history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_word  <= '0;
            prev_word <= '0;
        end else begin
            cur_word  <= codes_in;
            prev_word <= cur_word;
        end
    end

    // the tap history stage changes on the same edge as the FFE output register
    assign codes_out = prev_word;

endmodule

`default_nettype wire

//--- verilog/lane_ffe.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

module lane_ffe
    import rx_dsp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire code_word_t cur_word,
    input  wire code_word_t prev_word,
    input  wire ffe_cfg_t   cfg,
    output est_word_t       est_word
);

    // wide enough for the full tap sum plus a guard bit
    localparam int ACC_BITS = `CODE_BITS + `WEIGHT_BITS + $clog2(`FFE_TAPS) + 1;
    localparam int SEQ_LEN  = 2 * `CHANNEL_WIDTH;

    localparam logic signed [ACC_BITS-1:0] EST_MAX = (1 <<< (`EST_BITS - 1)) - 1;
    localparam logic signed [ACC_BITS-1:0] EST_MIN = -(1 <<< (`EST_BITS - 1));

    code_t                      seq     [SEQ_LEN];
    logic signed [ACC_BITS-1:0] acc     [`CHANNEL_WIDTH];
    logic signed [ACC_BITS-1:0] shifted [`CHANNEL_WIDTH];
    est_word_t                  est_next;

    // --------------------------------------------------
    // sample sequence across the word boundary
    // --------------------------------------------------
    always_comb begin
        for (int p = 0; p < `CHANNEL_WIDTH; p++) begin
            seq[p]                  = prev_word[p];
            seq[p + `CHANNEL_WIDTH] = cur_word[p];
        end
    end

    // --------------------------------------------------
    // multiply-accumulate, shift and clamp
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc[i] = '0;
            // taps with j > i reach into the previous word
            for (int j = 0; j < `FFE_TAPS; j++) begin
                acc[i] = acc[i]
                       + $signed(seq[`CHANNEL_WIDTH + i - j]) * $signed(cfg.weights[j][i]);
            end
            shifted[i] = acc[i] >>> cfg.shift[i];
        end
    end

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            if (shifted[i] > EST_MAX) begin
                est_next[i] = EST_MAX[`EST_BITS-1:0];
            end else if (shifted[i] < EST_MIN) begin
                est_next[i] = EST_MIN[`EST_BITS-1:0];
            end else begin
                est_next[i] = shifted[i][`EST_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            est_word <= '0;
        end else begin
            est_word <= est_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pam4_slicer.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

module pam4_slicer
    import rx_dsp_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire est_word_t                   est_word,
    input  wire logic signed [`EST_BITS-1:0] bit_level,
    output sym_word_t                        sym_word
);

    // one extra bit so that negating the most negative level cannot wrap
    logic signed [`EST_BITS:0] pos_level;
    logic signed [`EST_BITS:0] neg_level;
    sym_word_t                 sym_next;

    assign pos_level = {bit_level[`EST_BITS-1], bit_level};
    assign neg_level = -pos_level;

    // thermometer code, bit 0 is the lowest threshold
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            sym_next[i][0] = $signed(est_word[i]) > neg_level;
            sym_next[i][1] = $signed(est_word[i]) > 0;
            sym_next[i][2] = $signed(est_word[i]) > pos_level;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sym_word <= '0;
        end else begin
            sym_word <= sym_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/symbol_aligner.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

module symbol_aligner
    import rx_dsp_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire sym_word_t sym_word,
    input  wire align_t    align_pos,
    output sym_word_t      symbols_out
);

    sym_word_t prev_sym;
    sym_t      seq [2 * `CHANNEL_WIDTH];
    sym_word_t window;

    // older word first, same order as the equalizer sequence
    always_comb begin
        for (int p = 0; p < `CHANNEL_WIDTH; p++) begin
            seq[p]                  = prev_sym[p];
            seq[p + `CHANNEL_WIDTH] = sym_word[p];
        end
    end

    // the window start moves the lane boundary by align_pos samples
    always_comb begin
        for (int m = 0; m < `CHANNEL_WIDTH; m++) begin
            window[m] = seq[int'(align_pos) + m];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_sym    <= '0;
            symbols_out <= '0;
        end else begin
            prev_sym    <= sym_word;
            symbols_out <= window;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rx_dsp_datapath.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

module rx_dsp_datapath
    import rx_dsp_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire code_word_t                  act_codes_in,

    input  wire ffe_cfg_t                    ffe_cfg,
    input  wire logic signed [`EST_BITS-1:0] bit_level,
    input  wire align_t                      align_pos,

    output est_word_t                        est_syms_out,
    output code_word_t                       act_codes_out,
    output sym_word_t                        symbols_out
);

    code_word_t cur_word;
    code_word_t prev_word;
    est_word_t  est_word;
    sym_word_t  sym_word;

    // --------------------------------------------------
    // code history and equalizer
    // --------------------------------------------------
    code_delay_line code_delay_line_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .codes_in  (act_codes_in),
        .cur_word  (cur_word),
        .prev_word (prev_word),
        .codes_out (act_codes_out)
    );

    lane_ffe lane_ffe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cur_word  (cur_word),
        .prev_word (prev_word),
        .cfg       (ffe_cfg),
        .est_word  (est_word)
    );

    // estimates leave in step with their codes for adaptation
    assign est_syms_out = est_word;

    // --------------------------------------------------
    // decision and symbol alignment
    // --------------------------------------------------
    pam4_slicer pam4_slicer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .est_word  (est_word),
        .bit_level (bit_level),
        .sym_word  (sym_word)
    );

    symbol_aligner symbol_aligner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sym_word    (sym_word),
        .align_pos   (align_pos),
        .symbols_out (symbols_out)
    );

endmodule

`default_nettype wire

//--- dv/rx_dsp_assertions.sv
`default_nettype none

module rx_dsp_assertions
    import rx_dsp_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire code_word_t act_codes_in,
    input wire code_word_t act_codes_out,
    input wire est_word_t  est_syms_out,
    input wire sym_word_t  symbols_out,
    input wire sym_word_t  sym_word
);

    // a thermometer lane never has a zero above a one
    function automatic logic is_thermo(input sym_word_t w);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < $size(w); i++) begin
            if ((w[i] & (w[i] + sym_t'(1))) != '0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    thermo_legal: assert property (@(posedge clk) disable iff (!rst_n)
        is_thermo(sym_word) && is_thermo(symbols_out))
        else $error("a symbol lane holds an illegal thermometer code");

    code_latency: assert property (@(posedge clk)
        rst_n && $past(rst_n, 1) && $past(rst_n, 2) |-> act_codes_out == $past(act_codes_in, 2))
        else $error("act_codes_out differs from the input word two cycles earlier");

    reset_zero: assert property (@(posedge clk)
        !rst_n |=> act_codes_out == '0 && est_syms_out == '0 && symbols_out == '0)
        else $error("outputs are not zero in the cycle after reset");

endmodule

bind rx_dsp_datapath rx_dsp_assertions rx_dsp_assertions_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .act_codes_in  (act_codes_in),
    .act_codes_out (act_codes_out),
    .est_syms_out  (est_syms_out),
    .symbols_out   (symbols_out),
    .sym_word      (sym_word)
);

`default_nettype wire

//--- dv/rx_dsp_tb.sv
`default_nettype none

`include "rx_dsp_cfg.svh"

module rx_dsp_tb
    import rx_dsp_pkg::*;
();

    localparam longint EST_HI = (longint'(1) <<< (`EST_BITS - 1)) - 1;
    localparam longint EST_LO = -(longint'(1) <<< (`EST_BITS - 1));

    logic                        clk;
    logic                        rst_n;
    code_word_t                  act_codes_in;
    ffe_cfg_t                    ffe_cfg;
    logic signed [`EST_BITS-1:0] bit_level;
    align_t                      align_pos;
    est_word_t                   est_syms_out;
    code_word_t                  act_codes_out;
    sym_word_t                   symbols_out;

    logic [31:0] rng_state;
    code_word_t  code_hist [$];
    int          code_errors = 0;
    int          est_errors = 0;
    int          sym_errors = 0;
    int          other_errors = 0;

    rx_dsp_datapath rx_dsp_datapath_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic code_word_t rand_codes();
        code_word_t w;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            w[i] = code_t'(next_rand());
        end
        return w;
    endfunction

    // --------------------------------------------------
    // reference model, word k is the k-th word since reset
    // --------------------------------------------------
    function automatic code_word_t code_at(input int k);
        return (k < 0) ? '0 : code_hist[k];
    endfunction

    function automatic est_word_t model_est(input int k);
        code_word_t seq [2];
        est_word_t  e;
        longint     acc;
        int         p;
        seq[0] = code_at(k - 1);
        seq[1] = code_at(k);
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = 0;
            for (int j = 0; j < `FFE_TAPS; j++) begin
                p = `CHANNEL_WIDTH + i - j;
                acc += longint'($signed(seq[p / `CHANNEL_WIDTH][p % `CHANNEL_WIDTH]))
                     * longint'($signed(ffe_cfg.weights[j][i]));
            end
            acc = acc >>> ffe_cfg.shift[i];
            acc = (acc > EST_HI) ? EST_HI : (acc < EST_LO) ? EST_LO : acc;
            e[i] = est_t'(acc);
        end
        return e;
    endfunction

    // symbols of word k, zero while the slicer register still holds its reset value
    function automatic sym_word_t model_sym(input int k);
        sym_word_t s;
        est_word_t e;
        int        v;
        e = model_est(k);
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            v = $signed(e[i]);
            s[i] = {v > int'(bit_level), v > 0, v > -int'(bit_level)};
        end
        return (k < -2) ? '0 : s;
    endfunction

    function automatic sym_word_t model_window(input int k);
        sym_word_t seq [2];
        sym_word_t w;
        int        p;
        seq[0] = model_sym(k - 1);
        seq[1] = model_sym(k);
        for (int m = 0; m < `CHANNEL_WIDTH; m++) begin
            p = int'(align_pos) + m;
            w[m] = seq[p / `CHANNEL_WIDTH][p % `CHANNEL_WIDTH];
        end
        return w;
    endfunction

    task automatic check_codes(input string name, input code_word_t exp, input code_word_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            code_errors++;
        end
    endtask

    task automatic check_est(input string name, input est_word_t exp, input est_word_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            est_errors++;
        end
    endtask

    task automatic check_syms(input string name, input sym_word_t exp, input sym_word_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            sym_errors++;
        end
    endtask

    task automatic check_all_zero();
        check_codes("act_codes_out", '0, act_codes_out);
        check_est("est_syms_out", '0, est_syms_out);
        check_syms("symbols_out", '0, symbols_out);
    endtask

    // drive word n and check what the edge capturing it leaves on the outputs
    task automatic step(input code_word_t w);
        int n;
        n = code_hist.size();
        code_hist.push_back(w);
        act_codes_in = w;
        @(posedge clk);
        #1;
        check_codes("act_codes_out", code_at(n - 1), act_codes_out);
        check_est("est_syms_out", model_est(n - 1), est_syms_out);
        check_syms("symbols_out", model_window(n - 3), symbols_out);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        act_codes_in = '0;
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;
        code_hist.delete();
    endtask

    // tap 0 at one with no shift passes each code through as its estimate
    task automatic set_unity_taps();
        ffe_cfg = '0;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            ffe_cfg.weights[0][i] = 8'sd1;
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset();
        set_unity_taps();
        bit_level = 12'sd20;
        apply_reset();
        check_all_zero();
        for (int k = 0; k < 6; k++) begin
            step(rand_codes());
        end
        rst_n = 1'b0;
        @(posedge clk);
        #1;
        check_all_zero();
    endtask

    task automatic test_code_delay();
        code_word_t marker;
        int         edges;
        apply_reset();
        marker = rand_codes();
        marker[0] = code_t'(90);
        act_codes_in = marker;
        edges = 0;
        while (act_codes_out !== marker && edges < 16) begin
            @(posedge clk);
            #1;
            edges++;
            act_codes_in = '0;
        end
        if (act_codes_out !== marker) begin
            $display("timeout: the marker word never reached act_codes_out");
            other_errors++;
        end else if (edges != 2) begin
            $display("the marker word reached act_codes_out after %0d cycles, not 2", edges);
            other_errors++;
        end
        apply_reset();
        for (int k = 0; k < 16; k++) begin
            step(rand_codes());
        end
    endtask

    task automatic test_ffe_random();
        logic [31:0] r;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            for (int j = 0; j < `FFE_TAPS; j++) begin
                ffe_cfg.weights[j][i] = weight_t'(next_rand());
            end
            r = next_rand();
            ffe_cfg.shift[i] = shift_t'(2 + r[2:0]);
        end
        bit_level = 12'sd200;
        apply_reset();
        for (int k = 0; k < 24; k++) begin
            step(rand_codes());
        end
    endtask

    task automatic test_ffe_saturation();
        est_word_t lim;
        ffe_cfg = '0;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            for (int j = 0; j < `FFE_TAPS; j++) begin
                ffe_cfg.weights[j][i] = 8'sd127;
            end
        end
        apply_reset();
        for (int k = 0; k < 3; k++) begin
            step({`CHANNEL_WIDTH{code_t'(127)}});
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            lim[i] = est_t'(EST_HI);
        end
        check_est("est_syms_out", lim, est_syms_out);
        for (int k = 0; k < 3; k++) begin
            step({`CHANNEL_WIDTH{code_t'(-128)}});
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            lim[i] = est_t'(EST_LO);
        end
        check_est("est_syms_out", lim, est_syms_out);
    endtask

    // codes on both sides of each threshold with bit_level at 40
    task automatic test_slicer();
        int         codes [12] = '{-41, -40, -39, -1, 0, 1, 39, 40, 41, -100, 100, 0};
        code_word_t w;
        set_unity_taps();
        bit_level = 12'sd40;
        apply_reset();
        for (int k = 0; k < 12 / `CHANNEL_WIDTH; k++) begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                w[i] = code_t'(codes[`CHANNEL_WIDTH * k + i]);
            end
            step(w);
        end
        for (int k = 0; k < 4; k++) begin
            step('0);
        end
    endtask

    task automatic test_align();
        set_unity_taps();
        bit_level = 12'sd32;
        for (int a = 0; a < `CHANNEL_WIDTH; a++) begin
            align_pos = align_t'(a);
            apply_reset();
            for (int k = 0; k < 12; k++) begin
                step(rand_codes());
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        act_codes_in = '0;
        ffe_cfg = '0;
        bit_level = '0;
        align_pos = '0;
        rng_state = 32'hae4a;
        test_reset();
        test_code_delay();
        test_ffe_random();
        test_ffe_saturation();
        test_slicer();
        test_align();
        $display("errors: codes %0d, estimates %0d, symbols %0d, other %0d",
                 code_errors, est_errors, sym_errors, other_errors);
        if (code_errors + est_errors + sym_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rx_dsp_datapath.f
+incdir+verilog
verilog/rx_dsp_pkg.sv
verilog/code_delay_line.sv
verilog/lane_ffe.sv
verilog/pam4_slicer.sv
verilog/symbol_aligner.sv
verilog/rx_dsp_datapath.sv
dv/rx_dsp_assertions.sv
dv/rx_dsp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f rx_dsp_datapath.f --top-module rx_dsp_tb -Mdir obj_dir -o rx_dsp_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rx_dsp_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
